//--- rvIsaPkg.sv
package rvIsaPkg;

    typedef logic [31:0] wordT;     // Data or instruction word.
    typedef logic [4:0]  regAddrT;
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [2:0]  immSrcT;
    typedef logic [1:0]  resultSrcT;
    typedef logic [1:0]  aluOpT;
    typedef logic [2:0]  memSizeT;  // One-hot access size.

    // Opcodes. addi and slli share the OP-IMM opcode.
    localparam opcodeT opRType  = 7'b0110011;
    localparam opcodeT opImm    = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;

    localparam funct3T funct3Addi = 3'b000;

    // Load and store width field.
    localparam funct3T f3Byte  = 3'b000;
    localparam funct3T f3Half  = 3'b001;
    localparam funct3T f3Word  = 3'b010;
    localparam funct3T f3ByteU = 3'b100;
    localparam funct3T f3HalfU = 3'b101;

    // ALU function field.
    localparam funct3T f3AddSub = 3'b000;
    localparam funct3T f3Sll    = 3'b001;
    localparam funct3T f3Slt    = 3'b010;
    localparam funct3T f3Sltu   = 3'b011;
    localparam funct3T f3Xor    = 3'b100;
    localparam funct3T f3Srl    = 3'b101;
    localparam funct3T f3Or     = 3'b110;
    localparam funct3T f3And    = 3'b111;

    localparam immSrcT immI = 3'd0;  // Also used by jalr.
    localparam immSrcT immU = 3'd1;
    localparam immSrcT immS = 3'd2;
    localparam immSrcT immB = 3'd3;
    localparam immSrcT immJ = 3'd4;

    localparam resultSrcT resultAlu = 2'd0;
    localparam resultSrcT resultMem = 2'd1;
    localparam resultSrcT resultPc4 = 2'd2;

    localparam aluOpT aluOpMem    = 2'd0;
    localparam aluOpT aluOpBranch = 2'd1;
    localparam aluOpT aluOpRType  = 2'd2;
    localparam aluOpT aluOpImm    = 2'd3;

    localparam memSizeT memNone = 3'b000;
    localparam memSizeT memByte = 3'b001;
    localparam memSizeT memHalf = 3'b010;
    localparam memSizeT memWord = 3'b100;

endpackage

//--- pipeCtrlPkg.sv
package pipeCtrlPkg;

    import rvIsaPkg::*;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSll,
        aluSrl,
        aluSra,
        aluSlt,
        aluSltu
    } aluCtrlT;

    // Main decoder output.
    typedef struct packed {
        logic      regWrite;
        resultSrcT resultSrc;
        logic      aluSrc;     // Second ALU operand is the immediate.
        immSrcT    immSrc;
        logic      branch;
        logic      jump;
        aluOpT     aluOp;
        logic      memRead;
        logic      memWrite;
        memSizeT   memSize;
        logic      loadSigned; // Sign-extend the loaded value.
        logic      isJalr;
        logic      isLui;
    } ctrlBundleT;

    // Everything execute needs from decode.
    typedef struct packed {
        logic      valid;
        wordT      pc;
        wordT      rs1Data;
        wordT      rs2Data;
        regAddrT   rs1;
        regAddrT   rs2;
        regAddrT   rd;
        wordT      imm;
        aluCtrlT   aluCtrl;
        funct3T    funct3;     // Branch condition for execute.
        logic      regWrite;
        resultSrcT resultSrc;
        logic      aluSrc;
        logic      branch;
        logic      jump;
        logic      memRead;
        logic      memWrite;
        memSizeT   memSize;
        logic      loadSigned;
        logic      isJalr;
        logic      isLui;
    } idExPacketT;

endpackage

//--- mainDecoder.sv
`timescale 1ns/10ps

module mainDecoder
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  opcodeT     opcode,
    input  funct3T     funct3,
    output ctrlBundleT ctrl
);

    typedef enum logic [3:0] {
        kindUndef,
        kindRType,
        kindAddi,
        kindSlli,
        kindLoad,
        kindLui,
        kindStore,
        kindBranch,
        kindJal,
        kindJalr
    } instrKindT;

    instrKindT kind;

    // Loads and stores with a bad width fall back to undefined.
    always_comb begin
        case (opcode)
            opRType:  kind = kindRType;
            opImm:    kind = (funct3 == funct3Addi) ? kindAddi : kindSlli;
            opLoad:   kind = (funct3 inside {f3Byte, f3Half, f3Word, f3ByteU, f3HalfU}) ?
                             kindLoad : kindUndef;
            opLui:    kind = kindLui;
            opStore:  kind = (funct3 inside {f3Byte, f3Half, f3Word}) ? kindStore : kindUndef;
            opBranch: kind = kindBranch;
            opJal:    kind = kindJal;
            opJalr:   kind = kindJalr;
            default:  kind = kindUndef;
        endcase
    end

    always_comb begin
        ctrl           = '0;
        ctrl.resultSrc = resultAlu;
        ctrl.immSrc    = immI;
        ctrl.aluOp     = aluOpImm;  // Immediate class unless overridden.
        ctrl.memSize   = memNone;

        case (kind)
            kindRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluOpRType;
            end
            kindAddi, kindSlli: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            kindLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resultMem;
                ctrl.aluSrc    = 1'b1;
                ctrl.aluOp     = aluOpMem;  // Address add.
                ctrl.memRead   = 1'b1;
            end
            kindLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immU;
                ctrl.isLui    = 1'b1;
            end
            kindStore: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.immSrc   = immS;
                ctrl.aluOp    = aluOpMem;
                ctrl.memWrite = 1'b1;
            end
            kindBranch: begin
                ctrl.immSrc = immB;
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluOpBranch;
            end
            kindJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resultPc4;  // Link address.
                ctrl.immSrc    = immJ;
                ctrl.jump      = 1'b1;
            end
            kindJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.resultSrc = resultPc4;
                ctrl.jump      = 1'b1;
                ctrl.isJalr    = 1'b1;
            end
            default: ;
        endcase

        // Access width, only for memory kinds.
        if (kind == kindLoad) begin
            case (funct3)
                f3Byte, f3ByteU: ctrl.memSize = memByte;
                f3Half, f3HalfU: ctrl.memSize = memHalf;
                f3Word:          ctrl.memSize = memWord;
                default:         ctrl.memSize = memNone;
            endcase
            ctrl.loadSigned = (funct3 == f3Byte) || (funct3 == f3Half);
        end else if (kind == kindStore) begin
            case (funct3)
                f3Byte:  ctrl.memSize = memByte;
                f3Half:  ctrl.memSize = memHalf;
                f3Word:  ctrl.memSize = memWord;
                default: ctrl.memSize = memNone;
            endcase
        end
    end

endmodule

//--- aluDecoder.sv
`timescale 1ns/10ps

module aluDecoder
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  aluOpT   aluOp,
    input  funct3T  funct3,
    input  logic    funct7b5,  // Instruction bit 30.
    output aluCtrlT aluCtrl
);

    always_comb begin
        aluCtrl = aluAdd;
        case (aluOp)
            aluOpMem:    aluCtrl = aluAdd;
            aluOpBranch: aluCtrl = aluSub;  // Compare by subtraction.
            default: begin
                // R-type and immediate share the funct3 table.
                case (funct3)
                    f3AddSub: begin
                        // Bit 30 of addi is immediate data, never sub.
                        if (aluOp == aluOpRType && funct7b5) begin
                            aluCtrl = aluSub;
                        end else begin
                            aluCtrl = aluAdd;
                        end
                    end
                    f3Sll:   aluCtrl = aluSll;
                    f3Slt:   aluCtrl = aluSlt;
                    f3Sltu:  aluCtrl = aluSltu;
                    f3Xor:   aluCtrl = aluXor;
                    f3Srl:   aluCtrl = funct7b5 ? aluSra : aluSrl;  // srai as well.
                    f3Or:    aluCtrl = aluOr;
                    f3And:   aluCtrl = aluAnd;
                    default: aluCtrl = aluAdd;
                endcase
            end
        endcase
    end

endmodule

//--- immExtender.sv
`timescale 1ns/10ps

module immExtender
    import rvIsaPkg::*;
(
    input  wordT   instr,
    input  immSrcT immSrc,
    output wordT   imm
);

    logic signBit;

    assign signBit = instr[31];

    always_comb begin
        case (immSrc)
            immI: imm = {{20{signBit}}, instr[31:20]};
            immU: imm = {instr[31:12], 12'b0};  // No extension needed.
            immS: imm = {{20{signBit}}, instr[31:25], instr[11:7]};
            immB: begin
                // Halfword offset, bit 0 implied.
                imm = {{19{signBit}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            immJ: begin
                imm = {{11{signBit}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

//--- registerFile.sv
`timescale 1ns/10ps

module registerFile
    import rvIsaPkg::*;
#(
    parameter int numRegs = 32
) (
    input  logic    clk,
    input  logic    arstN,
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  logic    wbEn,
    input  regAddrT wbAddr,
    input  wordT    wbData,
    output wordT    rs1Data,
    output wordT    rs2Data
);

    localparam int idxW = $clog2(numRegs);

    wordT regs [numRegs];

    // x0 and indices past the file are not writable.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbAddr != '0 && int'(wbAddr) < numRegs) begin
            regs[wbAddr[idxW-1:0]] <= wbData;
        end
    end

    // Same-cycle writeback is forwarded to the read port.
    function automatic wordT readPort(regAddrT addr);
        wordT value;
        if (addr == '0 || int'(addr) >= numRegs) begin
            value = '0;
        end else if (wbEn && addr == wbAddr) begin
            value = wbData;
        end else begin
            value = regs[addr[idxW-1:0]];
        end
        return value;
    endfunction

    always_comb begin
        rs1Data = readPort(rs1);
        rs2Data = readPort(rs2);
    end

endmodule

//--- decodeStage.sv
`timescale 1ns/10ps

module decodeStage
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;
#(
    parameter int numRegs = 32
) (
    input  logic       clk,
    input  logic       arstN,
    input  wordT       instr,
    input  wordT       pc,
    input  logic       instrValid,
    input  logic       stall,
    input  logic       flush,
    input  logic       wbEn,
    input  regAddrT    wbAddr,
    input  wordT       wbData,
    output idExPacketT idEx
);

    ctrlBundleT ctrl;
    aluCtrlT    aluCtrl;
    wordT       imm;
    wordT       rs1Data;
    wordT       rs2Data;
    regAddrT    rs1;
    regAddrT    rs2;
    regAddrT    rd;
    funct3T     funct3;
    idExPacketT rawPacket;
    idExPacketT nextPacket;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];

    // Clears valid and every flag with an effect outside execute.
    function automatic idExPacketT bubble(idExPacketT p);
        idExPacketT b;
        b          = p;
        b.valid    = 1'b0;
        b.regWrite = 1'b0;
        b.memRead  = 1'b0;
        b.memWrite = 1'b0;
        b.branch   = 1'b0;
        b.jump     = 1'b0;
        return b;
    endfunction

    mainDecoder i_mainDecoder (
        .opcode (instr[6:0]),
        .funct3 (funct3),
        .ctrl   (ctrl)
    );

    aluDecoder i_aluDecoder (
        .aluOp    (ctrl.aluOp),
        .funct3   (funct3),
        .funct7b5 (instr[30]),
        .aluCtrl  (aluCtrl)
    );

    immExtender i_immExtender (
        .instr  (instr),
        .immSrc (ctrl.immSrc),
        .imm    (imm)
    );

    registerFile #(
        .numRegs (numRegs)
    ) i_registerFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    always_comb begin
        rawPacket.valid      = instrValid;
        rawPacket.pc         = pc;
        rawPacket.rs1Data    = rs1Data;
        rawPacket.rs2Data    = rs2Data;
        rawPacket.rs1        = rs1;
        rawPacket.rs2        = rs2;
        rawPacket.rd         = rd;
        rawPacket.imm        = imm;
        rawPacket.aluCtrl    = aluCtrl;
        rawPacket.funct3     = funct3;
        rawPacket.regWrite   = ctrl.regWrite;
        rawPacket.resultSrc  = ctrl.resultSrc;
        rawPacket.aluSrc     = ctrl.aluSrc;
        rawPacket.branch     = ctrl.branch;
        rawPacket.jump       = ctrl.jump;
        rawPacket.memRead    = ctrl.memRead;
        rawPacket.memWrite   = ctrl.memWrite;
        rawPacket.memSize    = ctrl.memSize;
        rawPacket.loadSigned = ctrl.loadSigned;
        rawPacket.isJalr     = ctrl.isJalr;
        rawPacket.isLui      = ctrl.isLui;
    end

    assign nextPacket = instrValid ? rawPacket : bubble(rawPacket);

    // Flush wins over stall.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else if (flush) begin
            idEx <= bubble(nextPacket);
        end else if (!stall) begin
            idEx <= nextPacket;
        end
    end

endmodule

//--- decodeStage_assert.sv
`timescale 1ns/10ps

module decodeStageAssert
    import pipeCtrlPkg::*;
(
    input logic       clk,
    input logic       arstN,
    input logic       stall,
    input logic       flush,
    input idExPacketT idEx
);

    flushBubble: assert property (@(posedge clk) disable iff (!arstN)
        flush |=> !idEx.valid)
        else $error("idEx valid after a flush edge");

    stallHold: assert property (@(posedge clk) disable iff (!arstN)
        stall && !flush |=> $stable(idEx))
        else $error("idEx changed during a stall");

    memExclusive: assert property (@(posedge clk) disable iff (!arstN)
        !(idEx.memRead && idEx.memWrite))
        else $error("memRead and memWrite both set");

    noWriteInvalid: assert property (@(posedge clk) disable iff (!arstN)
        !idEx.valid |-> !idEx.regWrite)
        else $error("regWrite set on an invalid packet");

endmodule

bind decodeStage decodeStageAssert i_decodeStageAssert (
    .clk   (clk),
    .arstN (arstN),
    .stall (stall),
    .flush (flush),
    .idEx  (idEx)
);

//--- decodeStageChecker.sv
`timescale 1ns/10ps

module decodeStageChecker
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;
(
    input  logic       clk,
    input  idExPacketT idEx,
    input  idExPacketT expected,
    input  logic       checkEn,
    input  int         testId,
    output int         errorCount,
    output int         testsDone
);

    idExPacketT expLatched;
    logic       pending;
    int         idLatched;
    int         rowErrors;

    initial begin
        pending    = 1'b0;
        errorCount = 0;
        testsDone  = 0;
    end

    // Row applied before the edge.
    always @(posedge clk) begin
        pending    <= checkEn;
        expLatched <= expected;
        idLatched  <= testId;
    end

    task automatic checkField(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            rowErrors++;
        end
    endtask

    // idEx is stable at the falling edge.
    always @(negedge clk) begin
        if (pending) begin
            rowErrors = 0;
            checkField("valid", 32'(expLatched.valid), 32'(idEx.valid));
            checkField("pc", expLatched.pc, idEx.pc);
            checkField("rs1Data", expLatched.rs1Data, idEx.rs1Data);
            checkField("rs2Data", expLatched.rs2Data, idEx.rs2Data);
            checkField("rs1", 32'(expLatched.rs1), 32'(idEx.rs1));
            checkField("rs2", 32'(expLatched.rs2), 32'(idEx.rs2));
            checkField("rd", 32'(expLatched.rd), 32'(idEx.rd));
            checkField("imm", expLatched.imm, idEx.imm);
            checkField("aluCtrl", 32'(expLatched.aluCtrl), 32'(idEx.aluCtrl));
            checkField("funct3", 32'(expLatched.funct3), 32'(idEx.funct3));
            checkField("regWrite", 32'(expLatched.regWrite), 32'(idEx.regWrite));
            checkField("resultSrc", 32'(expLatched.resultSrc), 32'(idEx.resultSrc));
            checkField("aluSrc", 32'(expLatched.aluSrc), 32'(idEx.aluSrc));
            checkField("branch", 32'(expLatched.branch), 32'(idEx.branch));
            checkField("jump", 32'(expLatched.jump), 32'(idEx.jump));
            checkField("memRead", 32'(expLatched.memRead), 32'(idEx.memRead));
            checkField("memWrite", 32'(expLatched.memWrite), 32'(idEx.memWrite));
            checkField("memSize", 32'(expLatched.memSize), 32'(idEx.memSize));
            checkField("loadSigned", 32'(expLatched.loadSigned), 32'(idEx.loadSigned));
            checkField("isJalr", 32'(expLatched.isJalr), 32'(idEx.isJalr));
            checkField("isLui", 32'(expLatched.isLui), 32'(idEx.isLui));
            if (rowErrors == 0) begin
                $display("Test %0d: pass", idLatched);
            end else begin
                $display("Test %0d: FAIL with %0d wrong fields", idLatched, rowErrors);
            end
            errorCount = errorCount + rowErrors;
            testsDone  = testsDone + 1;
        end
    end

endmodule

//--- decodeStageTb.sv
`timescale 1ns/10ps

module decodeStageTb
    import rvIsaPkg::*;
    import pipeCtrlPkg::*;
;

    // Mode bits are {valid, stall, flush, wbHit}.
    // Flag bits are {regWrite, memRead, memWrite, loadSigned, branch, jump, aluSrc,
    // isJalr, isLui}.
    typedef struct packed {
        wordT      instr;
        logic [3:0] mode;
        logic [8:0] flags;
        memSizeT   memSize;
        resultSrcT resultSrc;
        aluCtrlT   aluCtrl;
        wordT      imm;
    } rowT;

    logic       clk;
    logic       arstN;
    wordT       instr;
    wordT       pc;
    logic       instrValid;
    logic       stall;
    logic       flush;
    logic       wbEn;
    regAddrT    wbAddr;
    wordT       wbData;
    idExPacketT idEx;
    idExPacketT expected;
    idExPacketT prevExp;
    logic       checkEn;
    int         testId;
    int         errorCount;
    int         testsDone;
    int         seed;
    int         waitCycles;
    wordT       shadow [32];
    rowT        rows [$];

    decodeStage #(
        .numRegs (32)
    ) i_decodeStage (
        .clk        (clk),
        .arstN      (arstN),
        .instr      (instr),
        .pc         (pc),
        .instrValid (instrValid),
        .stall      (stall),
        .flush      (flush),
        .wbEn       (wbEn),
        .wbAddr     (wbAddr),
        .wbData     (wbData),
        .idEx       (idEx)
    );

    decodeStageChecker i_checker (
        .clk        (clk),
        .idEx       (idEx),
        .expected   (expected),
        .checkEn    (checkEn),
        .testId     (testId),
        .errorCount (errorCount),
        .testsDone  (testsDone)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic addRow(wordT i, logic [3:0] m, logic [8:0] f, memSizeT ms,
                          resultSrcT rs, aluCtrlT ac, wordT im);
        rowT r;
        r.instr     = i;
        r.mode      = m;
        r.flags     = f;
        r.memSize   = ms;
        r.resultSrc = rs;
        r.aluCtrl   = ac;
        r.imm       = im;
        rows.push_back(r);
    endtask

    // Packet the DUT should register for one table row.
    function automatic idExPacketT buildExpected(rowT r, wordT pcVal, wordT wbVal);
        idExPacketT e;
        e            = '0;
        e.valid      = r.mode[3];
        e.pc         = pcVal;
        e.rs1Data    = r.mode[0] ? wbVal : shadow[r.instr[19:15]];
        e.rs2Data    = shadow[r.instr[24:20]];
        e.rs1        = r.instr[19:15];
        e.rs2        = r.instr[24:20];
        e.rd         = r.instr[11:7];
        e.funct3     = r.instr[14:12];
        e.imm        = r.imm;
        e.aluCtrl    = r.aluCtrl;
        e.regWrite   = r.flags[8];
        e.memRead    = r.flags[7];
        e.memWrite   = r.flags[6];
        e.loadSigned = r.flags[5];
        e.branch     = r.flags[4];
        e.jump       = r.flags[3];
        e.aluSrc     = r.flags[2];
        e.isJalr     = r.flags[1];
        e.isLui      = r.flags[0];
        e.memSize    = r.memSize;
        e.resultSrc  = r.resultSrc;
        if (!r.mode[3] || r.mode[1]) begin  // Bubble.
            e.valid    = 1'b0;
            e.regWrite = 1'b0;
            e.memRead  = 1'b0;
            e.memWrite = 1'b0;
            e.branch   = 1'b0;
            e.jump     = 1'b0;
        end
        return e;
    endfunction

    task automatic fillTable();
        addRow(32'h002081B3, 4'b0100, 9'b100000000, memNone, resultAlu, aluAdd, 32'h2);
        addRow(32'h002081B3, 4'b1000, 9'b100000000, memNone, resultAlu, aluAdd, 32'h2);
        addRow(32'h40208233, 4'b1000, 9'b100000000, memNone, resultAlu, aluSub, 32'h402);
        addRow(32'h4020D2B3, 4'b1000, 9'b100000000, memNone, resultAlu, aluSra, 32'h402);
        addRow(32'h0020D2B3, 4'b1000, 9'b100000000, memNone, resultAlu, aluSrl, 32'h2);
        addRow(32'hFFF08313, 4'b1000, 9'b100000100, memNone, resultAlu, aluAdd, 32'hFFFFFFFF);
        addRow(32'h7FF08313, 4'b1000, 9'b100000100, memNone, resultAlu, aluAdd, 32'h7FF);
        addRow(32'h00309393, 4'b1000, 9'b100000100, memNone, resultAlu, aluSll, 32'h3);
        addRow(32'hFFC0A403, 4'b1000, 9'b110000100, memWord, resultMem, aluAdd, 32'hFFFFFFFC);
        addRow(32'h00408403, 4'b1000, 9'b110100100, memByte, resultMem, aluAdd, 32'h4);
        addRow(32'h00409403, 4'b1000, 9'b110100100, memHalf, resultMem, aluAdd, 32'h4);
        addRow(32'h0040C403, 4'b1000, 9'b110000100, memByte, resultMem, aluAdd, 32'h4);
        addRow(32'h0040D403, 4'b1000, 9'b110000100, memHalf, resultMem, aluAdd, 32'h4);
        addRow(32'h0040B403, 4'b1000, 9'b000000000, memNone, resultAlu, aluSltu, 32'h4);
        addRow(32'h0020A423, 4'b1000, 9'b001000100, memWord, resultAlu, aluAdd, 32'h8);
        addRow(32'hFE208FA3, 4'b1000, 9'b001000100, memByte, resultAlu, aluAdd, 32'hFFFFFFFF);
        addRow(32'h00209423, 4'b1000, 9'b001000100, memHalf, resultAlu, aluAdd, 32'h8);
        addRow(32'h0020B423, 4'b1000, 9'b000000000, memNone, resultAlu, aluSltu, 32'h2);
        addRow(32'h00208863, 4'b1000, 9'b000010000, memNone, resultAlu, aluSub, 32'h10);
        addRow(32'hFE209CE3, 4'b1000, 9'b000010000, memNone, resultAlu, aluSub, 32'hFFFFFFF8);
        addRow(32'h0010006F, 4'b1000, 9'b100001000, memNone, resultPc4, aluAdd, 32'h800);
        addRow(32'hFFDFF0EF, 4'b1000, 9'b100001000, memNone, resultPc4, aluAnd, 32'hFFFFFFFC);
        addRow(32'h00C100E7, 4'b1000, 9'b100001010, memNone, resultPc4, aluAdd, 32'hC);
        addRow(32'hABCDE4B7, 4'b1000, 9'b100000101, memNone, resultAlu, aluOr, 32'hABCDE000);
        addRow(32'h0000007F, 4'b1000, 9'b000000000, memNone, resultAlu, aluAdd, 32'h0);
        addRow(32'h00000533, 4'b1000, 9'b100000000, memNone, resultAlu, aluAdd, 32'h0);
        addRow(32'h002081B3, 4'b1001, 9'b100000000, memNone, resultAlu, aluAdd, 32'h2);
        addRow(32'hFFC0A403, 4'b1100, 9'b110000100, memWord, resultMem, aluAdd, 32'hFFFFFFFC);
        addRow(32'h002081B3, 4'b1110, 9'b100000000, memNone, resultAlu, aluAdd, 32'h2);
        addRow(32'h0020A423, 4'b0000, 9'b001000100, memWord, resultAlu, aluAdd, 32'h8);
        addRow(32'h0010006F, 4'b1010, 9'b100001000, memNone, resultPc4, aluAdd, 32'h800);
    endtask

    initial begin
        wordT value;
        seed       = 32'h6d83f6fb;
        arstN      = 1'b0;
        instr      = '0;
        pc         = '0;
        instrValid = 1'b0;
        stall      = 1'b1;  // Keeps the reset packet through preload.
        flush      = 1'b0;
        wbEn       = 1'b0;
        wbAddr     = '0;
        wbData     = '0;
        expected   = '0;
        prevExp    = '0;
        checkEn    = 1'b0;
        testId     = 0;
        fillTable();
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        // Random register contents, x0 included.
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            value  = $random(seed);
            wbEn   = 1'b1;
            wbAddr = regAddrT'(i);
            wbData = value;
            shadow[i] = (i == 0) ? '0 : value;
        end

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            value      = $random(seed);
            instr      = rows[i].instr;
            pc         = 32'h100 + 32'(i * 4);
            instrValid = rows[i].mode[3];
            stall      = rows[i].mode[2];
            flush      = rows[i].mode[1];
            wbEn       = rows[i].mode[0];
            wbAddr     = rows[i].instr[19:15];
            wbData     = value;
            if (rows[i].mode[2] && !rows[i].mode[1]) begin
                expected = prevExp;  // Held by the stall.
            end else begin
                expected = buildExpected(rows[i], pc, value);
                prevExp  = expected;
            end
            if (rows[i].mode[0] && rows[i].instr[19:15] != 5'd0) begin
                shadow[rows[i].instr[19:15]] = value;
            end
            testId  = i;
            checkEn = 1'b1;
        end
        @(negedge clk);
        checkEn = 1'b0;
        wbEn    = 1'b0;

        waitCycles = 0;
        while (testsDone < rows.size() && waitCycles < 50) begin
            @(posedge clk);
            waitCycles++;
        end

        if (testsDone < rows.size()) begin
            $display("Timeout: checker finished only %0d of %0d table rows",
                     testsDone, rows.size());
            $display("Test failures found");
        end else begin
            $display("Tests run: %0d, errors: %0d", testsDone, errorCount);
            if (errorCount == 0) begin
                $display("All tests passed!");
            end else begin
                $display("Test failures found");
            end
        end
        $finish;
    end

endmodule

//--- vlog.f
rvIsaPkg.sv
pipeCtrlPkg.sv
mainDecoder.sv
aluDecoder.sv
immExtender.sv
registerFile.sv
decodeStage.sv
decodeStage_assert.sv
decodeStageChecker.sv
decodeStageTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module decodeStageTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/simv)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed!"; then
    exit 0
else
    exit 1
fi
